/* source/periph_bus_pkg.sv */
package periph_bus_pkg;

	//=====================================================================
	// Near and far bus widths
	//=====================================================================

	// Near-side address below the top nibble
	parameter int ADDR_W = 28;

	// Read and write data
	parameter int DATA_W = 32;

	// Register index inside one peripheral
	parameter int REG_W = 2;

	// Bridge sequencing
	typedef enum logic [1:0] {
		BR_IDLE    = 2'd0,
		BR_ACCESS  = 2'd1,
		BR_RESPOND = 2'd2
	} bridge_state_e;

endpackage

/* source/periph_map_pkg.sv */
package periph_map_pkg;

	//=====================================================================
	// Address fields
	//=====================================================================

	parameter int SLOT_HI = 27;
	parameter int SLOT_LO = 24;
	parameter int REG_HI = 3;
	parameter int REG_LO = 2;

	// Peripheral slots, everything else is unmapped
	typedef enum logic [3:0] {
		SLOT_TIMER  = 4'd5,
		SLOT_IRQ    = 4'd8,
		SLOT_SYSREG = 4'd9
	} periph_slot_e;

	//=====================================================================
	// Register indexes per peripheral
	//=====================================================================

	typedef enum logic [periph_bus_pkg::REG_W-1:0] {
		TMR_COUNT   = 2'd0,
		TMR_COMPARE = 2'd1,
		TMR_CONTROL = 2'd2
	} timer_reg_e;

	typedef enum logic [periph_bus_pkg::REG_W-1:0] {
		IRQ_ENABLE  = 2'd0,
		IRQ_PENDING = 2'd1
	} irq_reg_e;

	typedef enum logic [periph_bus_pkg::REG_W-1:0] {
		SYS_DEVICE_ID = 2'd0,
		SYS_LEDS      = 2'd1,
		SYS_SOFT_IRQ  = 2'd2,
		SYS_SCRATCH   = 2'd3
	} sysreg_reg_e;

	// Interrupt source bits
	parameter int IRQ_SOURCES = 2;
	parameter int IRQ_TIMER_BIT = 0;
	parameter int IRQ_SOFT_BIT = 1;

endpackage

/* source/periph_bridge.sv */
`timescale 1ns/1ps

module periph_bridge (
	input  logic i_clock,
	input  logic i_rst_n,

	// Near side
	input  logic i_request,
	input  logic i_rw,
	input  logic [periph_bus_pkg::ADDR_W-1:0] i_address,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_wdata,
	output logic [periph_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,

	// Far side returns
	input  logic [periph_bus_pkg::DATA_W-1:0] i_timer_rdata,
	input  logic i_timer_ready,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_irq_rdata,
	input  logic i_irq_ready,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_sysreg_rdata,
	input  logic i_sysreg_ready,

	// Far side requests and shared lines
	output logic o_timer_request,
	output logic o_irq_request,
	output logic o_sysreg_request,
	output logic o_far_rw,
	output logic [periph_bus_pkg::REG_W-1:0] o_far_reg,
	output logic [periph_bus_pkg::DATA_W-1:0] o_far_wdata
);

	periph_bus_pkg::bridge_state_e state;

	logic [periph_map_pkg::SLOT_HI-periph_map_pkg::SLOT_LO:0] near_slot;
	logic [periph_map_pkg::SLOT_HI-periph_map_pkg::SLOT_LO:0] slot_q;
	logic near_mapped;
	logic sel_ready;
	logic [periph_bus_pkg::DATA_W-1:0] sel_rdata;
	logic [periph_bus_pkg::DATA_W-1:0] resp_q;

	assign near_slot = i_address[periph_map_pkg::SLOT_HI:periph_map_pkg::SLOT_LO];

	always_comb begin
		case (near_slot)
			periph_map_pkg::SLOT_TIMER,
			periph_map_pkg::SLOT_IRQ,
			periph_map_pkg::SLOT_SYSREG: near_mapped = 1'b1;
			default: near_mapped = 1'b0;
		endcase
	end

	// Return path of the latched slot
	always_comb begin
		case (slot_q)
			periph_map_pkg::SLOT_TIMER: begin
				sel_ready = i_timer_ready;
				sel_rdata = i_timer_rdata;
			end
			periph_map_pkg::SLOT_IRQ: begin
				sel_ready = i_irq_ready;
				sel_rdata = i_irq_rdata;
			end
			periph_map_pkg::SLOT_SYSREG: begin
				sel_ready = i_sysreg_ready;
				sel_rdata = i_sysreg_rdata;
			end
			default: begin
				sel_ready = 1'b0;
				sel_rdata = '0;
			end
		endcase
	end

	//=====================================================================
	// Sequencer
	//=====================================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= periph_bus_pkg::BR_IDLE;
			o_timer_request <= 1'b0;
			o_irq_request <= 1'b0;
			o_sysreg_request <= 1'b0;
		end else begin
			case (state)
				periph_bus_pkg::BR_IDLE: begin
					if (i_request && near_mapped) begin
						state <= periph_bus_pkg::BR_ACCESS;
						o_timer_request <= (near_slot == periph_map_pkg::SLOT_TIMER);
						o_irq_request <= (near_slot == periph_map_pkg::SLOT_IRQ);
						o_sysreg_request <= (near_slot == periph_map_pkg::SLOT_SYSREG);
					end else if (i_request) begin
						// Unmapped, answer at once
						state <= periph_bus_pkg::BR_RESPOND;
					end
				end
				periph_bus_pkg::BR_ACCESS: begin
					if (sel_ready) begin
						state <= periph_bus_pkg::BR_RESPOND;
						o_timer_request <= 1'b0;
						o_irq_request <= 1'b0;
						o_sysreg_request <= 1'b0;
					end
				end
				default: state <= periph_bus_pkg::BR_IDLE;
			endcase
		end
	end

	// Access latch and response capture
	always_ff @(posedge i_clock) begin
		if (state == periph_bus_pkg::BR_IDLE && i_request) begin
			slot_q <= near_slot;
			o_far_rw <= i_rw;
			o_far_reg <= i_address[periph_map_pkg::REG_HI:periph_map_pkg::REG_LO];
			o_far_wdata <= i_wdata;
			resp_q <= '0;
		end else if (state == periph_bus_pkg::BR_ACCESS && sel_ready) begin
			resp_q <= sel_rdata;
		end
	end

	assign o_ready = (state == periph_bus_pkg::BR_RESPOND);
	assign o_rdata = resp_q;

endmodule

/* source/sys_timer.sv */
`timescale 1ns/1ps

module sys_timer #(
	parameter int TICK_DIV = 1
) (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_request,
	input  logic i_rw,
	input  logic [periph_bus_pkg::REG_W-1:0] i_reg,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_wdata,
	output logic [periph_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_timer_irq
);

	localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [PRE_W-1:0] prescale;
	logic [periph_bus_pkg::DATA_W-1:0] count;
	logic [periph_bus_pkg::DATA_W-1:0] compare;
	logic enable;
	logic accept;

	// One access per request, ready blocks a repeat
	assign accept = i_request && !o_ready;

	//=====================================================================
	// Tick counter
	//=====================================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			prescale <= '0;
			count <= '0;
		end else if (enable) begin
			if (prescale == PRE_W'(TICK_DIV - 1)) begin
				prescale <= '0;
				count <= count + 1'b1;
			end else begin
				prescale <= prescale + 1'b1;
			end
		end else begin
			prescale <= '0;
		end
	end

	// Register writes and handshake
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			compare <= '1;
			enable <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= accept;
			if (accept && i_rw) begin
				case (i_reg)
					periph_map_pkg::TMR_COMPARE: compare <= i_wdata;
					periph_map_pkg::TMR_CONTROL: enable <= i_wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_rdata <= '0;
			case (i_reg)
				periph_map_pkg::TMR_COUNT: o_rdata <= count;
				periph_map_pkg::TMR_COMPARE: o_rdata <= compare;
				periph_map_pkg::TMR_CONTROL: o_rdata[0] <= enable;
				default: ;
			endcase
		end
	end

	assign o_timer_irq = enable && (count >= compare);

endmodule

/* source/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_request,
	input  logic i_rw,
	input  logic [periph_bus_pkg::REG_W-1:0] i_reg,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_wdata,
	input  logic [periph_map_pkg::IRQ_SOURCES-1:0] i_sources,
	output logic [periph_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt
);

	logic [periph_map_pkg::IRQ_SOURCES-1:0] src_q;
	logic [periph_map_pkg::IRQ_SOURCES-1:0] rising;
	logic [periph_map_pkg::IRQ_SOURCES-1:0] clear;
	logic [periph_map_pkg::IRQ_SOURCES-1:0] enable;
	logic [periph_map_pkg::IRQ_SOURCES-1:0] pending;
	logic accept;

	assign accept = i_request && !o_ready;
	assign rising = i_sources & ~src_q;

	// Write-one-to-clear on the pending register
	assign clear = (accept && i_rw && i_reg == periph_map_pkg::IRQ_PENDING) ?
		i_wdata[periph_map_pkg::IRQ_SOURCES-1:0] : '0;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			src_q <= '0;
			pending <= '0;
			enable <= '0;
			o_ready <= 1'b0;
		end else begin
			src_q <= i_sources;
			// New edge wins over a clear in the same cycle
			pending <= (pending & ~clear) | rising;
			o_ready <= accept;
			if (accept && i_rw && i_reg == periph_map_pkg::IRQ_ENABLE)
				enable <= i_wdata[periph_map_pkg::IRQ_SOURCES-1:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_rdata <= '0;
			case (i_reg)
				periph_map_pkg::IRQ_ENABLE:
					o_rdata[periph_map_pkg::IRQ_SOURCES-1:0] <= enable;
				periph_map_pkg::IRQ_PENDING:
					o_rdata[periph_map_pkg::IRQ_SOURCES-1:0] <= pending;
				default: ;
			endcase
		end
	end

	assign o_interrupt = |(pending & enable);

endmodule

/* source/sys_registers.sv */
`timescale 1ns/1ps

module sys_registers #(
	parameter logic [periph_bus_pkg::DATA_W-1:0] DEVICE_ID = 32'h0000_0003,
	parameter int LED_COUNT = 8
) (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_request,
	input  logic i_rw,
	input  logic [periph_bus_pkg::REG_W-1:0] i_reg,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_wdata,
	output logic [periph_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic [LED_COUNT-1:0] o_leds,
	output logic o_soft_irq
);

	logic [periph_bus_pkg::DATA_W-1:0] scratch;
	logic accept;
	logic wr;

	assign accept = i_request && !o_ready;
	assign wr = accept && i_rw;

	//=====================================================================
	// Writable registers
	//=====================================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_leds <= '0;
			scratch <= '0;
			o_soft_irq <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= accept;
			// Pulse lasts the single accept cycle
			o_soft_irq <= wr && (i_reg == periph_map_pkg::SYS_SOFT_IRQ) && i_wdata[0];
			if (wr && i_reg == periph_map_pkg::SYS_LEDS)
				o_leds <= i_wdata[LED_COUNT-1:0];
			if (wr && i_reg == periph_map_pkg::SYS_SCRATCH)
				scratch <= i_wdata;
		end
	end

	// Read path, soft trigger reads back zero
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_rdata <= '0;
			case (i_reg)
				periph_map_pkg::SYS_DEVICE_ID: o_rdata <= DEVICE_ID;
				periph_map_pkg::SYS_LEDS: o_rdata[LED_COUNT-1:0] <= o_leds;
				periph_map_pkg::SYS_SCRATCH: o_rdata <= scratch;
				default: ;
			endcase
		end
	end

endmodule

/* source/soc_periph.sv */
`timescale 1ns/1ps

module soc_periph #(
	parameter logic [periph_bus_pkg::DATA_W-1:0] DEVICE_ID = 32'h0000_0003,
	parameter int LED_COUNT = 8,
	parameter int TICK_DIV = 1
) (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_request,
	input  logic i_rw,
	input  logic [periph_bus_pkg::ADDR_W-1:0] i_address,
	input  logic [periph_bus_pkg::DATA_W-1:0] i_wdata,
	output logic [periph_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,
	output logic [LED_COUNT-1:0] o_leds
);

	//=====================================================================
	// Far bus
	//=====================================================================

	logic timer_request;
	logic irq_request;
	logic sysreg_request;
	logic far_rw;
	logic [periph_bus_pkg::REG_W-1:0] far_reg;
	logic [periph_bus_pkg::DATA_W-1:0] far_wdata;

	logic [periph_bus_pkg::DATA_W-1:0] timer_rdata;
	logic timer_ready;
	logic [periph_bus_pkg::DATA_W-1:0] irq_rdata;
	logic irq_ready;
	logic [periph_bus_pkg::DATA_W-1:0] sysreg_rdata;
	logic sysreg_ready;

	// Interrupt sources
	logic timer_irq;
	logic soft_irq;
	logic [periph_map_pkg::IRQ_SOURCES-1:0] irq_sources;

	assign irq_sources[periph_map_pkg::IRQ_TIMER_BIT] = timer_irq;
	assign irq_sources[periph_map_pkg::IRQ_SOFT_BIT] = soft_irq;

	periph_bridge bridge (
		.i_clock          (i_clock),
		.i_rst_n          (i_rst_n),
		.i_request        (i_request),
		.i_rw             (i_rw),
		.i_address        (i_address),
		.i_wdata          (i_wdata),
		.o_rdata          (o_rdata),
		.o_ready          (o_ready),
		.i_timer_rdata    (timer_rdata),
		.i_timer_ready    (timer_ready),
		.i_irq_rdata      (irq_rdata),
		.i_irq_ready      (irq_ready),
		.i_sysreg_rdata   (sysreg_rdata),
		.i_sysreg_ready   (sysreg_ready),
		.o_timer_request  (timer_request),
		.o_irq_request    (irq_request),
		.o_sysreg_request (sysreg_request),
		.o_far_rw         (far_rw),
		.o_far_reg        (far_reg),
		.o_far_wdata      (far_wdata)
	);

	// Slot 5
	sys_timer #(
		.TICK_DIV (TICK_DIV)
	) timer (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_request   (timer_request),
		.i_rw        (far_rw),
		.i_reg       (far_reg),
		.i_wdata     (far_wdata),
		.o_rdata     (timer_rdata),
		.o_ready     (timer_ready),
		.o_timer_irq (timer_irq)
	);

	// Slot 8
	irq_controller plic (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_request   (irq_request),
		.i_rw        (far_rw),
		.i_reg       (far_reg),
		.i_wdata     (far_wdata),
		.i_sources   (irq_sources),
		.o_rdata     (irq_rdata),
		.o_ready     (irq_ready),
		.o_interrupt (o_interrupt)
	);

	// Slot 9
	sys_registers #(
		.DEVICE_ID (DEVICE_ID),
		.LED_COUNT (LED_COUNT)
	) sysreg (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_request  (sysreg_request),
		.i_rw       (far_rw),
		.i_reg      (far_reg),
		.i_wdata    (far_wdata),
		.o_rdata    (sysreg_rdata),
		.o_ready    (sysreg_ready),
		.o_leds     (o_leds),
		.o_soft_irq (soft_irq)
	);

endmodule

/* bench/tb_soc_periph.sv */
`timescale 1ns/1ps

module tb_soc_periph;

	localparam logic [31:0] DEVICE_ID = 32'h0000_0003;
	localparam int LED_COUNT = 8;
	localparam int TICK_DIV = 2;
	localparam int ACCESS_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 200;

	logic i_clock;
	logic i_rst_n;
	logic i_request;
	logic i_rw;
	logic [periph_bus_pkg::ADDR_W-1:0] i_address;
	logic [periph_bus_pkg::DATA_W-1:0] i_wdata;
	logic [periph_bus_pkg::DATA_W-1:0] o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic [LED_COUNT-1:0] o_leds;

	// Shadow of the writable registers
	logic [31:0] shadow_compare;
	logic shadow_control;
	logic [1:0] shadow_enable;
	logic [1:0] shadow_pending;
	logic [LED_COUNT-1:0] shadow_leds;
	logic [31:0] shadow_scratch;

	// Reads waiting for the comparing process
	string read_names[$];
	logic [3:0] read_slots[$];
	logic [1:0] read_regs[$];
	logic [31:0] read_values[$];

	soc_periph #(
		.DEVICE_ID (DEVICE_ID),
		.LED_COUNT (LED_COUNT),
		.TICK_DIV  (TICK_DIV)
	) dut (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_request   (i_request),
		.i_rw        (i_rw),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.o_interrupt (o_interrupt),
		.o_leds      (o_leds)
	);

	always #20 i_clock = ~i_clock;

	//======================================================================
	// Reference model
	//======================================================================

	function automatic logic [31:0] ref_read(input logic [3:0] slot, input logic [1:0] idx);
		logic [31:0] value;
		value = '0;
		case (slot)
			periph_map_pkg::SLOT_TIMER: begin
				if (idx == 2'd1)
					value = shadow_compare;
				else if (idx == 2'd2)
					value[0] = shadow_control;
			end
			periph_map_pkg::SLOT_IRQ: begin
				if (idx == 2'd0)
					value[1:0] = shadow_enable;
				else if (idx == 2'd1)
					value[1:0] = shadow_pending;
			end
			periph_map_pkg::SLOT_SYSREG: begin
				if (idx == 2'd0)
					value = DEVICE_ID;
				else if (idx == 2'd1)
					value[LED_COUNT-1:0] = shadow_leds;
				else if (idx == 2'd3)
					value = shadow_scratch;
			end
			default: value = '0;
		endcase
		return value;
	endfunction

	// Apply one completed write to the shadow
	function automatic void update_shadow(input logic [3:0] slot, input logic [1:0] idx,
		input logic [31:0] data);
		case (slot)
			periph_map_pkg::SLOT_TIMER: begin
				if (idx == 2'd1)
					shadow_compare = data;
				else if (idx == 2'd2)
					shadow_control = data[0];
			end
			periph_map_pkg::SLOT_IRQ: begin
				if (idx == 2'd0)
					shadow_enable = data[1:0];
				else if (idx == 2'd1)
					shadow_pending = shadow_pending & ~data[1:0];
			end
			periph_map_pkg::SLOT_SYSREG: begin
				if (idx == 2'd1)
					shadow_leds = data[LED_COUNT-1:0];
				else if (idx == 2'd2 && data[0])
					shadow_pending[periph_map_pkg::IRQ_SOFT_BIT] = 1'b1;
				else if (idx == 2'd3)
					shadow_scratch = data;
			end
			default: ;
		endcase
	endfunction

	function automatic logic [27:0] make_addr(input logic [3:0] slot, input logic [1:0] idx);
		return {slot, 20'h0_0000, idx, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	//======================================================================
	// Near-side access tasks
	//======================================================================

	task automatic bus_access(input string name, input logic rw, input logic [3:0] slot,
		input logic [1:0] idx, input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw <= rw;
		i_address <= make_addr(slot, idx);
		i_wdata <= wdata;
		waited = 0;
		@(posedge i_clock);
		while (!o_ready && waited < ACCESS_TIMEOUT) begin
			@(posedge i_clock);
			waited++;
		end
		if (!o_ready) begin
			$display("Timeout: access '%s' got no o_ready within %0d cycles", name, waited);
			$display("SIMULATION FAILED");
			$fatal(1);
		end else begin
			rdata = o_rdata;
			i_request <= 1'b0;
			i_rw <= 1'b0;
		end
	endtask

	task automatic write_reg(input string name, input logic [3:0] slot, input logic [1:0] idx,
		input logic [31:0] data);
		logic [31:0] unused;
		bus_access(name, 1'b1, slot, idx, data, unused);
		update_shadow(slot, idx, data);
	endtask

	task automatic read_reg(input string name, input logic [3:0] slot, input logic [1:0] idx,
		output logic [31:0] data);
		bus_access(name, 1'b0, slot, idx, '0, data);
	endtask

	// Read and hand the result to the comparing process
	task automatic read_check(input string name, input logic [3:0] slot, input logic [1:0] idx);
		logic [31:0] data;
		read_reg(name, slot, idx, data);
		read_names.push_back(name);
		read_slots.push_back(slot);
		read_regs.push_back(idx);
		read_values.push_back(data);
	endtask

	task automatic wait_interrupt(input string name);
		int waited;
		waited = 0;
		while (!o_interrupt && waited < IRQ_TIMEOUT) begin
			@(posedge i_clock);
			waited++;
		end
		if (!o_interrupt) begin
			$display("Timeout: '%s' saw no o_interrupt within %0d cycles", name, waited);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// Comparing process runs between rising edges
	always @(negedge i_clock) begin : compare_reads
		string name;
		logic [3:0] slot;
		logic [1:0] idx;
		logic [31:0] actual;
		while (read_values.size() > 0) begin
			name = read_names.pop_front();
			slot = read_slots.pop_front();
			idx = read_regs.pop_front();
			actual = read_values.pop_front();
			check_value(name, ref_read(slot, idx), actual);
		end
	end

	//======================================================================
	// Test sequence
	//======================================================================

	initial begin
		logic [31:0] value;
		logic [31:0] count_a;
		logic [31:0] count_b;
		int unsigned seed_draw;

		seed_draw = $urandom(69742);
		i_clock = 1'b0;
		i_rst_n = 1'b0;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		shadow_compare = '1;
		shadow_control = 1'b0;
		shadow_enable = '0;
		shadow_pending = '0;
		shadow_leds = '0;
		shadow_scratch = '0;

		repeat (4) @(posedge i_clock);
		i_rst_n <= 1'b1;
		@(posedge i_clock);

		// Reset values
		check_value("reset o_ready", 32'd0, o_ready);
		check_value("reset o_interrupt", 32'd0, o_interrupt);
		check_value("reset o_leds", 32'd0, o_leds);
		read_check("reset timer compare", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COMPARE);
		read_check("reset timer control", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_CONTROL);
		read_check("reset irq enable", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_ENABLE);
		read_check("reset irq pending", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING);

		// Register read-back
		read_check("device id", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_DEVICE_ID);
		for (int i = 0; i < 6; i++) begin
			value = $urandom;
			write_reg("scratch write", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_SCRATCH, value);
			read_check("scratch read", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_SCRATCH);
			value = $urandom;
			write_reg("leds write", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_LEDS, value);
			read_check("leds read", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_LEDS);
			check_value("o_leds pins", shadow_leds, o_leds);
			value = $urandom;
			write_reg("compare write", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COMPARE, value);
			read_check("compare read", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COMPARE);
			value = $urandom;
			write_reg("enable write", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_ENABLE, value);
			read_check("enable read", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_ENABLE);
		end

		// Unmapped slots complete with zero and change nothing
		value = $urandom;
		write_reg("unmapped write slot 1", 4'd1, 2'd3, value);
		write_reg("unmapped write slot 15", 4'd15, 2'd1, ~value);
		write_reg("unmapped write slot 15 index 0", 4'd15, 2'd0, {value[31:2], ~shadow_enable});
		read_check("unmapped read slot 1", 4'd1, 2'd3);
		read_check("unmapped read slot 15", 4'd15, 2'd0);
		read_check("scratch after unmapped", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_SCRATCH);
		read_check("leds after unmapped", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_LEDS);
		read_check("compare after unmapped", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COMPARE);
		read_check("enable after unmapped", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_ENABLE);
		check_value("o_leds after unmapped", shadow_leds, o_leds);

		// Timer interrupt
		write_reg("enable timer source", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_ENABLE, 32'h1);
		write_reg("small compare", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COMPARE, 32'd6);
		write_reg("timer start", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_CONTROL, 32'h1);
		read_check("timer control on", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_CONTROL);
		read_reg("count first", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COUNT, count_a);
		read_reg("count second", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_COUNT, count_b);
		check_value("timer count increases", 32'd1, count_b > count_a);
		wait_interrupt("timer interrupt");
		shadow_pending[periph_map_pkg::IRQ_TIMER_BIT] = 1'b1;
		read_check("timer pending set", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING);
		write_reg("timer stop", periph_map_pkg::SLOT_TIMER, periph_map_pkg::TMR_CONTROL, 32'h0);
		write_reg("timer pending clear", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING,
			32'h1);
		check_value("interrupt after timer clear", 32'd0, o_interrupt);
		read_check("timer pending cleared", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING);

		// Software interrupt behind the mask
		write_reg("soft trigger", periph_map_pkg::SLOT_SYSREG, periph_map_pkg::SYS_SOFT_IRQ, 32'h1);
		read_check("soft pending set", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING);
		read_check("soft register reads zero", periph_map_pkg::SLOT_SYSREG,
			periph_map_pkg::SYS_SOFT_IRQ);
		check_value("masked soft interrupt", 32'd0, o_interrupt);
		write_reg("enable soft source", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_ENABLE, 32'h3);
		check_value("unmasked soft interrupt", 32'd1, o_interrupt);
		write_reg("soft pending clear", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING, 32'h2);
		check_value("interrupt after soft clear", 32'd0, o_interrupt);
		read_check("soft pending cleared", periph_map_pkg::SLOT_IRQ, periph_map_pkg::IRQ_PENDING);

		// Let the comparing process drain
		repeat (2) @(posedge i_clock);
		if (read_values.size() != 0) begin
			$display("Comparing process left %0d reads unchecked", read_values.size());
			$display("SIMULATION FAILED");
			$fatal(1);
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

/* soc_periph.f */
source/periph_bus_pkg.sv
source/periph_map_pkg.sv
source/periph_bridge.sv
source/sys_timer.sv
source/irq_controller.sv
source/sys_registers.sv
source/soc_periph.sv
bench/tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the soc_periph testbench with Verilator.
# The run passes only if the simulation output holds the pass line.

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal \
	-f soc_periph.f \
	--top-module tb_soc_periph \
	-Mdir obj_dir &&
./obj_dir/Vtb_soc_periph 2>&1 | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run_sim: simulation reported pass" ||
{ echo "run_sim: build or simulation did not pass"; exit 1; }
